/* rtl/cursor_consts.svh */
`ifndef CURSOR_CONSTS_SVH
`define CURSOR_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cursor outline geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// pixels painted along each edge of the outline
`define CURSOR_SIDE 5

// visible frame buffer size in pixels
`define SCREEN_W 160
`define SCREEN_H 120

// word address into the frame buffer, enough for SCREEN_W * SCREEN_H
`define ADDR_W 15

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// blink sequencing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define WHITE_CYCLES 12
`define BLACK_CYCLES 9

// done countdown start, done stays up one cycle longer than this
`define DONE_HOLD 24

`endif

/* rtl/cursor_pkg.sv */
`default_nettype none

`include "cursor_consts.svh"

package cursor_pkg;

    typedef logic [7:0] coord_t;

    // white is all ones, black is zero
    typedef logic [7:0] pixel_t;

    typedef logic [`ADDR_W-1:0] addr_t;

    typedef logic [2:0] step_t;

    typedef enum logic [3:0] {
        IDLE,
        EDGE_RIGHT,
        CLR_1,
        EDGE_DOWN,
        CLR_2,
        EDGE_LEFT,
        CLR_3,
        EDGE_UP,
        CLR_4,
        WAIT_WHITE,
        SET_BLACK,
        WAIT_BLACK,
        HOLD_DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

/* rtl/cursor_palette_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cursor_consts.svh"

module cursor_palette_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 init,
    input  logic                 white_done,
    input  logic                 black_done,
    input  cursor_pkg::step_t    step_count,
    output logic                 seq_clear,
    output logic                 step_clear,
    output logic                 paint,
    output logic                 move_x,
    output logic                 move_y,
    output logic                 forward,
    output logic                 time_white,
    output logic                 time_black,
    output logic                 done,
    output cursor_pkg::pixel_t   px_color
);

    localparam int DONE_W = $clog2(`DONE_HOLD + 1);

    cursor_pkg::ctrl_state_t state;
    cursor_pkg::ctrl_state_t state_next;
    logic [DONE_W-1:0]       done_cnt;
    logic                    edge_end;

    // last pixel of the current edge is being painted
    assign edge_end = (step_count == cursor_pkg::step_t'(`CURSOR_SIDE - 1));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // next state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        state_next = state;
        case (state)
            cursor_pkg::IDLE:
                state_next = init ? cursor_pkg::EDGE_RIGHT : cursor_pkg::IDLE;
            cursor_pkg::EDGE_RIGHT:
                state_next = edge_end ? cursor_pkg::CLR_1 : cursor_pkg::EDGE_RIGHT;
            cursor_pkg::CLR_1:
                state_next = cursor_pkg::EDGE_DOWN;
            cursor_pkg::EDGE_DOWN:
                state_next = edge_end ? cursor_pkg::CLR_2 : cursor_pkg::EDGE_DOWN;
            cursor_pkg::CLR_2:
                state_next = cursor_pkg::EDGE_LEFT;
            cursor_pkg::EDGE_LEFT:
                state_next = edge_end ? cursor_pkg::CLR_3 : cursor_pkg::EDGE_LEFT;
            cursor_pkg::CLR_3:
                state_next = cursor_pkg::EDGE_UP;
            cursor_pkg::EDGE_UP:
                state_next = edge_end ? cursor_pkg::CLR_4 : cursor_pkg::EDGE_UP;
            // white interval already served means this was the black outline
            cursor_pkg::CLR_4:
                state_next = white_done ? cursor_pkg::WAIT_BLACK : cursor_pkg::WAIT_WHITE;
            cursor_pkg::WAIT_WHITE:
                state_next = white_done ? cursor_pkg::SET_BLACK : cursor_pkg::WAIT_WHITE;
            cursor_pkg::SET_BLACK:
                state_next = cursor_pkg::EDGE_RIGHT;
            cursor_pkg::WAIT_BLACK:
                state_next = black_done ? cursor_pkg::HOLD_DONE : cursor_pkg::WAIT_BLACK;
            cursor_pkg::HOLD_DONE:
                state_next = (done_cnt == '0) ? cursor_pkg::IDLE : cursor_pkg::HOLD_DONE;
            default:
                state_next = cursor_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cursor_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // colour register and done countdown
    always_ff @(posedge clk) begin
        if (rst) begin
            px_color <= '1;
            done_cnt <= DONE_W'(`DONE_HOLD);
        end else begin
            case (state)
                cursor_pkg::IDLE: begin
                    px_color <= '1;
                    done_cnt <= DONE_W'(`DONE_HOLD);
                end
                cursor_pkg::SET_BLACK: begin
                    px_color <= '0;
                end
                cursor_pkg::HOLD_DONE: begin
                    if (done_cnt != '0) begin
                        done_cnt <= done_cnt - 1'b1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        seq_clear  = 1'b0;
        step_clear = 1'b0;
        paint      = 1'b0;
        move_x     = 1'b0;
        move_y     = 1'b0;
        forward    = 1'b0;
        time_white = 1'b0;
        time_black = 1'b0;
        done       = 1'b0;
        case (state)
            cursor_pkg::IDLE: begin
                seq_clear  = 1'b1;
                step_clear = 1'b1;
            end
            cursor_pkg::EDGE_RIGHT: begin
                paint   = 1'b1;
                move_x  = 1'b1;
                forward = 1'b1;
            end
            cursor_pkg::EDGE_DOWN: begin
                paint   = 1'b1;
                move_y  = 1'b1;
                forward = 1'b1;
            end
            cursor_pkg::EDGE_LEFT: begin
                paint  = 1'b1;
                move_x = 1'b1;
            end
            cursor_pkg::EDGE_UP: begin
                paint  = 1'b1;
                move_y = 1'b1;
            end
            cursor_pkg::CLR_1,
            cursor_pkg::CLR_2,
            cursor_pkg::CLR_3,
            cursor_pkg::CLR_4: begin
                step_clear = 1'b1;
            end
            cursor_pkg::WAIT_WHITE: begin
                time_white = 1'b1;
            end
            cursor_pkg::WAIT_BLACK: begin
                time_black = 1'b1;
            end
            cursor_pkg::HOLD_DONE: begin
                done = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/edge_step_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module edge_step_counter (
    input  logic              clk,
    input  logic              rst,
    input  logic              step_clear,
    input  logic              paint,
    output cursor_pkg::step_t step_count
);

    // pixels painted so far on this edge, clear wins over a paint
    always_ff @(posedge clk) begin
        if (rst) begin
            step_count <= '0;
        end else if (step_clear) begin
            step_count <= '0;
        end else if (paint) begin
            step_count <= step_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* rtl/cursor_position.sv */
`timescale 1ns/1ps
`default_nettype none

module cursor_position (
    input  logic               clk,
    input  logic               rst,
    input  logic               seq_clear,
    input  logic               paint,
    input  logic               move_x,
    input  logic               move_y,
    input  logic               forward,
    input  cursor_pkg::coord_t origin_x,
    input  cursor_pkg::coord_t origin_y,
    output cursor_pkg::coord_t cur_x,
    output cursor_pkg::coord_t cur_y
);

    cursor_pkg::coord_t step_x;
    cursor_pkg::coord_t step_y;

    // one pixel towards right/down when forward, else left/up
    always_comb begin
        step_x = forward ? cur_x + 1'b1 : cur_x - 1'b1;
        step_y = forward ? cur_y + 1'b1 : cur_y - 1'b1;
    end

    // the step lands after the current pixel has been painted
    always_ff @(posedge clk) begin
        if (rst) begin
            cur_x <= '0;
            cur_y <= '0;
        end else if (seq_clear) begin
            cur_x <= origin_x;
            cur_y <= origin_y;
        end else if (paint) begin
            if (move_x) begin
                cur_x <= step_x;
            end
            if (move_y) begin
                cur_y <= step_y;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/blink_timer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cursor_consts.svh"

module blink_timer (
    input  logic clk,
    input  logic rst,
    input  logic seq_clear,
    input  logic time_white,
    input  logic time_black,
    output logic white_done,
    output logic black_done
);

    localparam int MAX_CYC = (`WHITE_CYCLES > `BLACK_CYCLES) ? `WHITE_CYCLES : `BLACK_CYCLES;
    localparam int CNT_W   = $clog2(MAX_CYC + 1);

    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] cnt_next;
    logic [CNT_W-1:0] target;
    logic             timing;
    logic             hit;

    assign timing   = time_white | time_black;
    assign cnt_next = cnt + 1'b1;
    assign target   = time_white ? CNT_W'(`WHITE_CYCLES) : CNT_W'(`BLACK_CYCLES);

    // interval reached on this clock edge
    assign hit = timing && (cnt_next == target);

    // shared counter, starts over whenever no interval is being timed
    always_ff @(posedge clk) begin
        if (rst || seq_clear || !timing) begin
            cnt <= '0;
        end else begin
            cnt <= cnt_next;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // latched finished flags
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst || seq_clear) begin
            white_done <= 1'b0;
            black_done <= 1'b0;
        end else if (hit) begin
            if (time_white) begin
                white_done <= 1'b1;
            end
            if (time_black) begin
                black_done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/pixel_write_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cursor_consts.svh"

module pixel_write_port (
    input  logic               clk,
    input  logic               rst,
    input  logic               paint,
    input  cursor_pkg::coord_t cur_x,
    input  cursor_pkg::coord_t cur_y,
    input  cursor_pkg::pixel_t px_color,
    output logic               wr_en,
    output cursor_pkg::addr_t  wr_addr,
    output cursor_pkg::pixel_t wr_data
);

    cursor_pkg::addr_t lin_addr;

    // row major, y * SCREEN_W + x
    assign lin_addr = cursor_pkg::addr_t'(cur_y) * cursor_pkg::addr_t'(`SCREEN_W)
                    + cursor_pkg::addr_t'(cur_x);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= paint;
        end
    end

    // address and data only matter while wr_en is up
    always_ff @(posedge clk) begin
        wr_addr <= lin_addr;
        wr_data <= px_color;
    end

endmodule

`default_nettype wire

/* rtl/cursor_palette_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cursor_palette_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               init,
    input  cursor_pkg::coord_t origin_x,
    input  cursor_pkg::coord_t origin_y,
    output logic               wr_en,
    output cursor_pkg::addr_t  wr_addr,
    output cursor_pkg::pixel_t wr_data,
    output logic               done
);

    // controller strobes
    logic seq_clear;
    logic step_clear;
    logic paint;
    logic move_x;
    logic move_y;
    logic forward;
    logic time_white;
    logic time_black;

    cursor_pkg::pixel_t px_color;
    cursor_pkg::step_t  step_count;
    logic               white_done;
    logic               black_done;
    cursor_pkg::coord_t cur_x;
    cursor_pkg::coord_t cur_y;

    cursor_palette_ctrl ctrl0 (
        .clk        (clk),
        .rst        (rst),
        .init       (init),
        .white_done (white_done),
        .black_done (black_done),
        .step_count (step_count),
        .seq_clear  (seq_clear),
        .step_clear (step_clear),
        .paint      (paint),
        .move_x     (move_x),
        .move_y     (move_y),
        .forward    (forward),
        .time_white (time_white),
        .time_black (time_black),
        .done       (done),
        .px_color   (px_color)
    );

    edge_step_counter step0 (
        .clk        (clk),
        .rst        (rst),
        .step_clear (step_clear),
        .paint      (paint),
        .step_count (step_count)
    );

    cursor_position pos0 (
        .clk       (clk),
        .rst       (rst),
        .seq_clear (seq_clear),
        .paint     (paint),
        .move_x    (move_x),
        .move_y    (move_y),
        .forward   (forward),
        .origin_x  (origin_x),
        .origin_y  (origin_y),
        .cur_x     (cur_x),
        .cur_y     (cur_y)
    );

    blink_timer blink0 (
        .clk        (clk),
        .rst        (rst),
        .seq_clear  (seq_clear),
        .time_white (time_white),
        .time_black (time_black),
        .white_done (white_done),
        .black_done (black_done)
    );

    pixel_write_port wport0 (
        .clk      (clk),
        .rst      (rst),
        .paint    (paint),
        .cur_x    (cur_x),
        .cur_y    (cur_y),
        .px_color (px_color),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

endmodule

`default_nettype wire

/* tb/tb_cursor_palette.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cursor_consts.svh"

module tb_cursor_palette;

    localparam int OUTLINE_LEN  = 4 * `CURSOR_SIDE;
    localparam int SEQ_TIMEOUT  = 2000;
    localparam int DONE_TIMEOUT = 200;

    logic               clk;
    logic               rst;
    logic               init;
    cursor_pkg::coord_t origin_x;
    cursor_pkg::coord_t origin_y;
    logic               wr_en;
    cursor_pkg::addr_t  wr_addr;
    cursor_pkg::pixel_t wr_data;
    logic               done;

    int errors;
    int tests_run;
    int tests_failed;

    cursor_palette_top dut0 (
        .clk      (clk),
        .rst      (rst),
        .init     (init),
        .origin_x (origin_x),
        .origin_y (origin_y),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .done     (done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // address of the k-th outline pixel when walking right then down then left then up
    function automatic int outline_addr(input int ox, input int oy, input int k);
        int i;
        int x;
        int y;
        i = k % `CURSOR_SIDE;
        x = ox;
        y = oy;
        if (k / `CURSOR_SIDE == 0) begin
            x = ox + i;
        end else if (k / `CURSOR_SIDE == 1) begin
            x = ox + `CURSOR_SIDE;
            y = oy + i;
        end else if (k / `CURSOR_SIDE == 2) begin
            x = ox + `CURSOR_SIDE - i;
            y = oy + `CURSOR_SIDE;
        end else begin
            y = oy + `CURSOR_SIDE - i;
        end
        return y * `SCREEN_W + x;
    endfunction

    task automatic flag_error(input string msg);
        errors++;
        $display("FAILED at %0t: %s", $time, msg);
    endtask

    // inputs change 1 ns after the edge while outputs have settled
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one full blink sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic run_case(input int idx, input int ox, input int oy, input int exp_writes,
                            input int exp_done, input bit busy_poke);
        int writes;
        int cyc;
        int gap;
        int tail;
        int done_len;
        int exp_addr;
        int errors_before;
        logic [7:0] exp_data;
        errors_before = errors;
        writes = 0;
        gap = 0;
        tail = 0;
        done_len = 0;
        origin_x = ox[7:0];
        origin_y = oy[7:0];
        init = 1'b1;
        next_cycle();
        init = 1'b0;
        cyc = 0;
        while (!done && cyc < SEQ_TIMEOUT) begin
            next_cycle();
            cyc++;
            init = 1'b0;
            if (wr_en && !done) begin
                exp_addr = outline_addr(ox, oy, writes % OUTLINE_LEN);
                exp_data = (writes < OUTLINE_LEN) ? 8'hff : 8'h00;
                if (writes >= exp_writes) begin
                    flag_error($sformatf("case %0d extra write %0d", idx, writes));
                end else if (int'(wr_addr) != exp_addr) begin
                    flag_error($sformatf("case %0d write %0d addr %0d, expected %0d",
                                         idx, writes, wr_addr, exp_addr));
                end
                if (wr_data != exp_data) begin
                    flag_error($sformatf("case %0d write %0d data %02h, expected %02h",
                                         idx, writes, wr_data, exp_data));
                end
                writes++;
                // a start request in the middle of the black outline
                if (busy_poke && writes == OUTLINE_LEN + 5) begin
                    init = 1'b1;
                end
            end else if (writes == OUTLINE_LEN) begin
                gap++;
            end else if (!done && writes == exp_writes) begin
                tail++;
            end
        end
        if (!done) begin
            errors++;
            $display("timeout: done never rose in case %0d after %0d cycles", idx, cyc);
        end else begin
            if (writes != exp_writes) begin
                flag_error($sformatf("case %0d got %0d writes, expected %0d",
                                     idx, writes, exp_writes));
            end
            if (gap < `WHITE_CYCLES) begin
                flag_error($sformatf("case %0d only %0d idle cycles between outlines",
                                     idx, gap));
            end
            if (tail < `BLACK_CYCLES) begin
                flag_error($sformatf("case %0d only %0d idle cycles before done",
                                     idx, tail));
            end
            cyc = 0;
            while (done && cyc < DONE_TIMEOUT) begin
                if (wr_en) begin
                    flag_error($sformatf("case %0d write while done is high", idx));
                end
                done_len++;
                next_cycle();
                cyc++;
            end
            if (done) begin
                errors++;
                $display("timeout: done stayed high in case %0d", idx);
            end else if (done_len != exp_done) begin
                flag_error($sformatf("case %0d done lasted %0d cycles, expected %0d",
                                     idx, done_len, exp_done));
            end
        end
        tests_run++;
        if (errors != errors_before) begin
            tests_failed++;
        end
        $display("case %0d origin (%0d,%0d) busy start %0d: %s", idx, ox, oy, busy_poke,
                 (errors == errors_before) ? "passed" : "failed");
    endtask

    initial begin
        int fd;
        int ox;
        int oy;
        int n_wr;
        int n_done;
        int idx;
        int errors_before;
        string line;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        rst = 1'b1;
        init = 1'b0;
        origin_x = '0;
        origin_y = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // quiet outputs while nothing is started
        errors_before = errors;
        repeat (20) begin
            next_cycle();
            if (wr_en || done) begin
                flag_error("wr_en or done high after reset with init low");
            end
        end
        tests_run++;
        if (errors != errors_before) begin
            tests_failed++;
        end
        $display("reset state: %s", (errors == errors_before) ? "passed" : "failed");

        idx = 0;
        fd = $fopen("tb/cursor_input.dat", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open tb/cursor_input.dat");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if ($sscanf(line, "%d %d %d %d", ox, oy, n_wr, n_done) == 4) begin
                    run_case(idx, ox, oy, n_wr, n_done, idx % 2 == 1);
                    idx++;
                end
            end
            $fclose(fd);
            if (idx == 0) begin
                errors++;
                $display("no cases found in tb/cursor_input.dat");
            end
        end

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/cursor_input.dat */
# origin_x origin_y expected_writes expected_done_cycles (decimal)
# one case per line; every case after the first restarts at a new origin
0 0 40 25
10 20 40 25
100 50 40 25
154 114 40 25
77 3 40 25

/* list.f */
+incdir+rtl
rtl/cursor_pkg.sv
rtl/cursor_palette_ctrl.sv
rtl/edge_step_counter.sv
rtl/cursor_position.sv
rtl/blink_timer.sv
rtl/pixel_write_port.sv
rtl/cursor_palette_top.sv
tb/tb_cursor_palette.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the cursor testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f list.f \
        --top-module tb_cursor_palette -o sim_tb; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_tb)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "PASS: all tests" <<< "$sim_out"; then
    exit 0
fi

echo "simulation did not pass"
exit 1
